// ==== common/lpf_pkg.sv ====
package lpf_pkg;

    //////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////

    // Samples per clock, lane 0 oldest
    localparam int NUM_LANES  = 8;
    localparam int SAMPLE_W   = 12;

    // Symmetric 33-tap response, only odd taps and the center are nonzero
    localparam int NUM_TAPS   = 33;
    localparam int CENTER_TAP = 16;
    localparam int NUM_PAIRS  = 8;

    // Four old vectors plus the current one reach 32 samples back
    localparam int HIST_VECS  = 4;

    //////////////////////////////////////////////////
    // Fixed point
    //////////////////////////////////////////////////

    localparam int COEF_W     = 18;
    localparam int PAIR_W     = SAMPLE_W + 1;
    localparam int ACC_W      = 36;
    localparam int FRAC_SHIFT = 15;

    // Pair p covers taps 2p+1 and 31-2p, Q3.15
    // Index 7 first in the concatenation
    localparam logic [NUM_PAIRS-1:0][COEF_W-1:0] PAIR_COEF = {
        COEF_W'(10342),
        COEF_W'(-3216),
        COEF_W'(1672),
        COEF_W'(-949),
        COEF_W'(263),
        COEF_W'(-526),
        COEF_W'(105),
        COEF_W'(-23)
    };

    localparam logic [COEF_W-1:0] CENTER_COEF = COEF_W'(16384);

    //////////////////////////////////////////////////
    // Data path types
    //////////////////////////////////////////////////

    typedef logic [NUM_LANES-1:0][SAMPLE_W-1:0] sample_vec_t;

    // prev[0] is one vector back, prev[HIST_VECS-1] the oldest
    typedef struct packed {
        sample_vec_t [HIST_VECS-1:0] prev;
        sample_vec_t                 cur;
    } history_t;

    // Pre-added mirrored taps of one lane, plus the lone center sample
    typedef struct packed {
        logic [NUM_PAIRS-1:0][PAIR_W-1:0] pair;
        logic [PAIR_W-1:0]                center;
    } lane_pairs_t;

endpackage

// ==== fir/pair_preadder.sv ====
`timescale 1ns/1ps

module pair_preadder (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  lpf_pkg::history_t                             hist_i,
    output lpf_pkg::lane_pairs_t [lpf_pkg::NUM_LANES-1:0] pairs_o
);

    // Window of five vectors, oldest first
    lpf_pkg::sample_vec_t win [lpf_pkg::HIST_VECS+1];

    // Next-state pair sums for every lane
    lpf_pkg::lane_pairs_t [lpf_pkg::NUM_LANES-1:0] pairs_d;

    //////////////////////////////////////////////////
    // Sample window
    //////////////////////////////////////////////////

    assign win[lpf_pkg::HIST_VECS] = hist_i.cur;

    for (genvar v = 0; v < lpf_pkg::HIST_VECS; v++) begin : g_win
        assign win[v] = hist_i.prev[lpf_pkg::HIST_VECS-1-v];
    end

    //////////////////////////////////////////////////
    // Mirrored tap selection and pre-add
    //////////////////////////////////////////////////

    // Sample n-t of lane l sits at flat window position l - t + 32
    for (genvar l = 0; l < lpf_pkg::NUM_LANES; l++) begin : g_lane
        localparam int BASE   = l + lpf_pkg::HIST_VECS * lpf_pkg::NUM_LANES;
        localparam int POS_C  = BASE - lpf_pkg::CENTER_TAP;

        logic [lpf_pkg::SAMPLE_W-1:0] center_s;

        assign center_s = win[POS_C / lpf_pkg::NUM_LANES][POS_C % lpf_pkg::NUM_LANES];

        // Center tap has no partner, only sign extension
        assign pairs_d[l].center = {center_s[lpf_pkg::SAMPLE_W-1], center_s};

        for (genvar p = 0; p < lpf_pkg::NUM_PAIRS; p++) begin : g_pair
            // Odd tap and its mirror around the center
            localparam int TAP_NEAR = 2 * p + 1;
            localparam int TAP_FAR  = lpf_pkg::NUM_TAPS - 1 - TAP_NEAR;
            localparam int POS_N    = BASE - TAP_NEAR;
            localparam int POS_F    = BASE - TAP_FAR;

            logic [lpf_pkg::SAMPLE_W-1:0] near_s;
            logic [lpf_pkg::SAMPLE_W-1:0] far_s;

            assign near_s = win[POS_N / lpf_pkg::NUM_LANES][POS_N % lpf_pkg::NUM_LANES];
            assign far_s  = win[POS_F / lpf_pkg::NUM_LANES][POS_F % lpf_pkg::NUM_LANES];

            // One extra bit keeps the sum exact
            assign pairs_d[l].pair[p] = {near_s[lpf_pkg::SAMPLE_W-1], near_s} +
                                        {far_s[lpf_pkg::SAMPLE_W-1], far_s};
        end
    end

    //////////////////////////////////////////////////
    // Pair register stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pairs_o <= '0;
        end else begin
            pairs_o <= pairs_d;
        end
    end

endmodule

// ==== fir/sample_history.sv ====
`timescale 1ns/1ps

module sample_history (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  lpf_pkg::sample_vec_t in_i,
    output lpf_pkg::history_t    hist_o
);

    lpf_pkg::history_t hist_q;

    //////////////////////////////////////////////////
    // Shift chain of sample vectors
    //////////////////////////////////////////////////

    // Current vector moves into prev[0], the oldest falls off the end
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hist_q <= '0;
        end else begin
            hist_q.cur  <= in_i;
            hist_q.prev <= {hist_q.prev[lpf_pkg::HIST_VECS-2:0], hist_q.cur};
        end
    end

    // All 40 samples visible at once for the pre-adder
    assign hist_o = hist_q;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Each old slot holds what the slot before it held one clock earlier
    property p_prev_head;
        @(posedge clk_i) disable iff (!rst_n_i)
            $past(rst_n_i) |-> hist_o.prev[0] == $past(hist_o.cur);
    endproperty

    property p_prev_chain;
        @(posedge clk_i) disable iff (!rst_n_i)
            $past(rst_n_i) |->
                hist_o.prev[lpf_pkg::HIST_VECS-1:1] ==
                $past(hist_o.prev[lpf_pkg::HIST_VECS-2:0]);
    endproperty

    a_prev_head : assert property (p_prev_head)
        else $error("history head slot lost the current vector");

    a_prev_chain : assert property (p_prev_chain)
        else $error("history chain did not shift by one vector");

endmodule

// ==== fir/tap_accumulator.sv ====
`timescale 1ns/1ps

module tap_accumulator (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  lpf_pkg::lane_pairs_t [lpf_pkg::NUM_LANES-1:0] pairs_i,
    output lpf_pkg::sample_vec_t                          out_o
);

    // Full-precision convolution sum per lane, Q.15
    logic signed [lpf_pkg::ACC_W-1:0] acc [lpf_pkg::NUM_LANES];

    //////////////////////////////////////////////////
    // Multiply and accumulate
    //////////////////////////////////////////////////

    // Operands are sign extended to the accumulator width before the multiply,
    // so the 13x18 products stay exact
    always_comb begin
        for (int l = 0; l < lpf_pkg::NUM_LANES; l++) begin
            // Center term first
            acc[l] = $signed(pairs_i[l].center) * $signed(lpf_pkg::CENTER_COEF);

            for (int p = 0; p < lpf_pkg::NUM_PAIRS; p++) begin
                acc[l] = acc[l] +
                         $signed(pairs_i[l].pair[p]) * $signed(lpf_pkg::PAIR_COEF[p]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // Bit slice is the floor of acc / 2^15, upper bits wrap
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_o <= '0;
        end else begin
            for (int l = 0; l < lpf_pkg::NUM_LANES; l++) begin
                out_o[l] <= acc[l][lpf_pkg::FRAC_SHIFT +: lpf_pkg::SAMPLE_W];
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Any reset cycle flushes the output vector on the next clock
    property p_reset_clears_out;
        @(posedge clk_i) !rst_n_i |=> out_o == '0;
    endproperty

    a_reset_clears_out : assert property (p_reset_clears_out)
        else $error("output not cleared after reset");

endmodule

// ==== project.f ====
+incdir+tb
common/lpf_pkg.sv
fir/sample_history.sv
fir/pair_preadder.sv
fir/tap_accumulator.sv
rtl/lpf_top.sv
tb/lpf_tb.sv

// ==== rtl/lpf_top.sv ====
`timescale 1ns/1ps

module lpf_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  lpf_pkg::sample_vec_t in_i,
    output lpf_pkg::sample_vec_t out_o
);

    // Registered history of the last five vectors
    lpf_pkg::history_t hist;

    // Per-lane pre-added tap pairs
    lpf_pkg::lane_pairs_t [lpf_pkg::NUM_LANES-1:0] pairs;

    //////////////////////////////////////////////////
    // Three register stages, history to output
    //////////////////////////////////////////////////

    sample_history u_history (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .in_i    (in_i),
        .hist_o  (hist)
    );

    pair_preadder u_preadder (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .hist_i  (hist),
        .pairs_o (pairs)
    );

    tap_accumulator u_accumulator (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .pairs_i (pairs),
        .out_o   (out_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the low-pass filter testbench with Verilator.
# Exit status is nonzero if the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=lpf_sim

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f project.f \
    --top-module lpf_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

"./$BUILD_DIR/$SIM_BIN"
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit "$sim_status"
fi

exit 0

// ==== tb/lpf_ref_model.svh ====
`ifndef LPF_REF_MODEL_SVH
`define LPF_REF_MODEL_SVH

//////////////////////////////////////////////////
// Stimulus source
//////////////////////////////////////////////////

// Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

//////////////////////////////////////////////////
// Filter model
//////////////////////////////////////////////////

// Every sample since the last reset release, index n = 8 * vector + lane
int sample_log [$];

// Impulse response scaled by 2^15, symmetric around the center tap
function automatic int tap_coef(input int t);
    int d;
    if (t < 0 || t >= lpf_pkg::NUM_TAPS) begin
        return 0;
    end
    d = (t > lpf_pkg::CENTER_TAP) ? t - lpf_pkg::CENTER_TAP : lpf_pkg::CENTER_TAP - t;
    case (d)
        0:       return 16384;
        1:       return 10342;
        3:       return -3216;
        5:       return 1672;
        7:       return -949;
        9:       return 263;
        11:      return -526;
        13:      return 105;
        15:      return -23;
        default: return 0;
    endcase
endfunction

function automatic void clear_log();
    sample_log.delete();
endfunction

function automatic void append_sample(input logic [lpf_pkg::SAMPLE_W-1:0] s);
    sample_log.push_back(int'($signed(s)));
endfunction

// Anything before the log start reads as a zero sample
function automatic int log_sample(input int n);
    if (n < 0 || n >= sample_log.size()) begin
        return 0;
    end
    return sample_log[n];
endfunction

// Direct convolution, floor by 2^15, low 12 bits kept
function automatic logic [lpf_pkg::SAMPLE_W-1:0] ref_output(input int n);
    longint acc;
    acc = 0;
    for (int t = 0; t < lpf_pkg::NUM_TAPS; t++) begin
        acc = acc + longint'(tap_coef(t)) * longint'(log_sample(n - t));
    end
    acc = acc >>> lpf_pkg::FRAC_SHIFT;
    return acc[lpf_pkg::SAMPLE_W-1:0];
endfunction

`endif

// ==== tb/lpf_tb.sv ====
`timescale 1ns/1ps

module lpf_tb;

    localparam int          RESET_CYCLES   = 5;
    localparam int          RANDOM_CYCLES  = 400;
    localparam int          RESTART_CYCLES = 60;
    localparam int          LATENCY        = 3;
    localparam int          DC_SETTLE_VECS = 5;
    localparam int          SETTLE_LIMIT   = 16;
    localparam int          DRAIN_LIMIT    = 8;
    localparam int          WATCHDOG_NS    = 100_000;
    localparam int          DC_LEVEL       = 1000;
    localparam int          IMPULSE_LEVEL  = 1024;
    localparam logic [31:0] LFSR_SEED      = 32'he4af8d48;

    logic                 clk;
    logic                 rst_n;
    lpf_pkg::sample_vec_t in_vec;
    lpf_pkg::sample_vec_t out_vec;

    logic [31:0] lfsr_q;
    int          vec_count;
    int          last_checked;
    bit          impulse_on;
    int          impulse_pos;

    `include "lpf_ref_model.svh"

    lpf_top DUT (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .in_i    (in_vec),
        .out_o   (out_vec)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic draw_sample(output logic [lpf_pkg::SAMPLE_W-1:0] s);
        for (int b = 0; b < lpf_pkg::SAMPLE_W; b++) begin
            s[b] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic random_vector(output lpf_pkg::sample_vec_t v);
        logic [lpf_pkg::SAMPLE_W-1:0] s;
        for (int l = 0; l < lpf_pkg::NUM_LANES; l++) begin
            draw_sample(s);
            v[l] = s;
        end
    endtask

    // Floor of 1024 * h[d] / 2^15 around the injected sample
    function automatic logic [lpf_pkg::SAMPLE_W-1:0] impulse_response(input int n);
        int p;
        p = IMPULSE_LEVEL * tap_coef(n - impulse_pos);
        p = p >>> lpf_pkg::FRAC_SHIFT;
        return p[lpf_pkg::SAMPLE_W-1:0];
    endfunction

    // Output on screen now belongs to the vector driven LATENCY clocks ago
    task automatic check_output();
        int                           base;
        logic [lpf_pkg::SAMPLE_W-1:0] exp_s;
        logic [lpf_pkg::SAMPLE_W-1:0] got_s;
        base = (vec_count - LATENCY) * lpf_pkg::NUM_LANES;
        for (int l = 0; l < lpf_pkg::NUM_LANES; l++) begin
            got_s = out_vec[l];
            exp_s = ref_output(base + l);
            assert (got_s == exp_s) else
                abort_run($sformatf("ERROR: %0t ns lane %0d got %0d expected %0d",
                                    $time, l, $signed(got_s), $signed(exp_s)));
            if (impulse_on) begin
                exp_s = impulse_response(base + l);
                assert (got_s == exp_s) else
                    abort_run($sformatf("ERROR: %0t ns lane %0d impulse got %0d expected %0d",
                                        $time, l, $signed(got_s), $signed(exp_s)));
            end
        end
        last_checked = vec_count - LATENCY;
    endtask

    task automatic drive_and_log(input lpf_pkg::sample_vec_t v);
        in_vec = v;
        for (int l = 0; l < lpf_pkg::NUM_LANES; l++) begin
            append_sample(v[l]);
        end
        vec_count++;
    endtask

    task automatic step_vector(input lpf_pkg::sample_vec_t v);
        @(negedge clk);
        check_output();
        drive_and_log(v);
    endtask

    //////////////////////////////////////////////////
    // Reset sequencing
    //////////////////////////////////////////////////

    task automatic enter_reset();
        lpf_pkg::sample_vec_t junk;
        @(negedge clk);
        check_output();
        random_vector(junk);
        rst_n  = 1'b0;
        in_vec = junk;
    endtask

    task automatic hold_in_reset(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (out_vec == '0) else
                abort_run($sformatf("ERROR: %0t ns output %h not zero during reset",
                                    $time, out_vec));
        end
    endtask

    // Model restarts with an empty log, matching the cleared history
    task automatic release_reset(input lpf_pkg::sample_vec_t v);
        @(negedge clk);
        assert (out_vec == '0) else
            abort_run($sformatf("ERROR: %0t ns output %h not zero at reset release",
                                $time, out_vec));
        clear_log();
        vec_count    = 0;
        last_checked = -LATENCY - 1;
        rst_n        = 1'b1;
        drive_and_log(v);
    endtask

    //////////////////////////////////////////////////
    // Phases
    //////////////////////////////////////////////////

    task automatic wait_dc_settle();
        lpf_pkg::sample_vec_t         dc;
        logic [lpf_pkg::SAMPLE_W-1:0] dc_out;
        int                           gain;
        int                           waited;
        bit                           settled;
        gain = 0;
        for (int t = 0; t < lpf_pkg::NUM_TAPS; t++) begin
            gain = gain + tap_coef(t);
        end
        dc_out = lpf_pkg::SAMPLE_W'((DC_LEVEL * gain) >>> lpf_pkg::FRAC_SHIFT);
        for (int l = 0; l < lpf_pkg::NUM_LANES; l++) begin
            dc[l] = lpf_pkg::SAMPLE_W'(DC_LEVEL);
        end
        waited  = 0;
        settled = 1'b0;
        while (!settled) begin
            if (waited >= SETTLE_LIMIT) begin
                abort_run("Timeout: DC input never settled to its steady output");
            end
            step_vector(dc);
            waited++;
            settled = (out_vec == {lpf_pkg::NUM_LANES{dc_out}});
        end
        assert (waited <= DC_SETTLE_VECS + LATENCY) else
            abort_run($sformatf("ERROR: %0t ns DC settled after %0d vectors", $time, waited));
        repeat (3) step_vector(dc);
    endtask

    task automatic drain_pipeline();
        int target;
        int guard;
        target = vec_count - 1;
        guard  = 0;
        while (last_checked < target) begin
            if (guard >= DRAIN_LIMIT) begin
                abort_run("Timeout: pipeline did not drain the last vectors");
            end
            step_vector('0);
            guard++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: simulation ran past its time limit");
    end

    initial begin
        lpf_pkg::sample_vec_t v;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_vec       = '0;
        lfsr_q       = LFSR_SEED;
        vec_count    = 0;
        last_checked = -LATENCY - 1;
        impulse_on   = 1'b0;
        impulse_pos  = 0;
        clear_log();

        // Reset, then quiet input after release
        hold_in_reset(RESET_CYCLES - 1);
        release_reset('0);
        repeat (6) step_vector('0);

        // Single impulse in lane 3, tail crosses four vector boundaries
        v           = '0;
        v[3]        = lpf_pkg::SAMPLE_W'(IMPULSE_LEVEL);
        impulse_pos = vec_count * lpf_pkg::NUM_LANES + 3;
        impulse_on  = 1'b1;
        step_vector(v);
        repeat (8) step_vector('0);
        impulse_on  = 1'b0;

        wait_dc_settle();

        // Full-range noise, wrapping outputs included
        repeat (RANDOM_CYCLES) begin
            random_vector(v);
            step_vector(v);
        end

        // Reset in the middle of the stream
        enter_reset();
        hold_in_reset(2);
        random_vector(v);
        release_reset(v);
        repeat (RESTART_CYCLES) begin
            random_vector(v);
            step_vector(v);
        end
        drain_pipeline();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
